// ==== Makefile ====
# Verilator simulation of the pitch interpolator

VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_pitch_interp
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fail if the log reports an error"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then \
		echo "simulation FAILED"; \
		exit 1; \
	fi
	@grep -q "sim passed" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/pitch_defines.svh ====
`ifndef PITCH_DEFINES_SVH
`define PITCH_DEFINES_SVH

// excitation memory
`define EXC_AW 8
`define EXC_DEPTH 256

// sample and accumulator widths
`define DATA_W 16
`define ACC_W 32

// interpolation filter
`define L_INTER 10 // taps per side
`define UP_SAMP 3 // 1/3 resolution
`define COEF_AW 5

// rounding constant added before taking the upper half
`define ROUND_K 32'h0000_8000

`endif

// ==== common/pitch_pkg.sv ====
`include "pitch_defines.svh"

package pitch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sequencer states

	typedef enum logic [4:0] {
		IDLE,
		NEGATE_FRAC,
		ADJUST_FRAC,
		J_LOOP,
		SET_C1,
		SET_C2,
		I_LOOP,
		MAC_X1,
		MAC_X2,
		STORE,
		ACK_HOLD
	} ctrl_state_e;

	////////////////////////////////////////////////////////////////////////////
	// operator opcodes

	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_NEGATE
	} op16_e;

	typedef enum logic [1:0] {
		OP_L_MAC, // la + L_mult(ma, mb)
		OP_L_ADD,
		OP_NONE
	} op32_e;

	////////////////////////////////////////////////////////////////////////////
	// structs

	typedef struct packed {
		logic [`EXC_AW-1:0] base;
		logic [15:0] t0;
		logic signed [15:0] frac;
		logic [15:0] l_subfr;
	} pitch_req_t;

	typedef struct packed {
		op16_e op16;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		op32_e op32;
		logic [`ACC_W-1:0] la;
		logic [`ACC_W-1:0] lb;
		logic [`DATA_W-1:0] ma; // multiplier operands
		logic [`DATA_W-1:0] mb;
	} op_req_t;

	typedef struct packed {
		logic [`DATA_W-1:0] r16;
		logic [`ACC_W-1:0] r32;
	} op_rsp_t;

	typedef struct packed {
		logic [`EXC_AW-1:0] addr;
		logic [`DATA_W-1:0] wdata;
		logic we;
	} mem_port_t;

endpackage

// ==== files.f ====
+incdir+common
common/pitch_pkg.sv
source/basic_ops.sv
source/exc_memory.sv
source/inter_rom.sv
pred_lt_3/pred_lt_3_ctrl.sv
source/pitch_interp_top.sv
tests/tb_pitch_interp.sv

// ==== pred_lt_3/pred_lt_3_ctrl.sv ====
`timescale 1ns/1ps
`include "pitch_defines.svh"

module pred_lt_3_ctrl
(
	input logic clk,
	input logic reset,
	input logic req,
	input pitch_pkg::pitch_req_t req_data,
	output logic ack,
	output pitch_pkg::op_req_t ops_req,
	input pitch_pkg::op_rsp_t ops_rsp,
	output pitch_pkg::mem_port_t eng_mem,
	input logic [`DATA_W-1:0] eng_rdata,
	output logic [`COEF_AW-1:0] coef_addr,
	input logic [`DATA_W-1:0] coef
);

	pitch_pkg::ctrl_state_e state, state_next;

	pitch_pkg::pitch_req_t req_q; // held for the whole run
	logic [15:0] j, j_inc;
	logic [3:0] i; // 0..10
	logic [`COEF_AW-1:0] k; // 3*i
	logic [`EXC_AW-1:0] x0, x1, x2;
	logic [`COEF_AW-1:0] c1, c2;
	logic [`DATA_W-1:0] frac1;
	logic [`ACC_W-1:0] s;

	assign j_inc = j + 16'd1;
	assign ack = (state == pitch_pkg::ACK_HOLD);

	//////////////////////////////////////////////////////////////////////////
	// next state, memory and ROM addressing

	always_comb
	begin
		state_next = state;
		eng_mem = '0;
		coef_addr = '0;
		case (state)
			pitch_pkg::IDLE:
				if (req)
					state_next = pitch_pkg::NEGATE_FRAC;
			pitch_pkg::NEGATE_FRAC:
				state_next = pitch_pkg::ADJUST_FRAC;
			pitch_pkg::ADJUST_FRAC:
				state_next = pitch_pkg::J_LOOP;
			pitch_pkg::J_LOOP:
				state_next = (j < req_q.l_subfr) ? pitch_pkg::SET_C1 : pitch_pkg::ACK_HOLD;
			pitch_pkg::SET_C1:
				state_next = pitch_pkg::SET_C2;
			pitch_pkg::SET_C2:
				state_next = pitch_pkg::I_LOOP;
			pitch_pkg::I_LOOP:
			begin
				if (i < `L_INTER)
				begin
					eng_mem.addr = x1 - `EXC_AW'(i); // x1[-i]
					coef_addr = c1 + k;
					state_next = pitch_pkg::MAC_X1;
				end
				else
				begin
					eng_mem.addr = req_q.base + j[`EXC_AW-1:0]; // exc[j] = round(s)
					eng_mem.wdata = ops_rsp.r32[`ACC_W-1:`ACC_W-`DATA_W];
					eng_mem.we = 1'b1;
					state_next = pitch_pkg::STORE;
				end
			end
			pitch_pkg::MAC_X1:
			begin
				eng_mem.addr = x2 + `EXC_AW'(i); // x2[i]
				coef_addr = c2 + k;
				state_next = pitch_pkg::MAC_X2;
			end
			pitch_pkg::MAC_X2:
				state_next = pitch_pkg::I_LOOP;
			pitch_pkg::STORE:
				state_next = (j_inc < req_q.l_subfr) ? pitch_pkg::J_LOOP : pitch_pkg::ACK_HOLD;
			pitch_pkg::ACK_HOLD:
				if (!req)
					state_next = pitch_pkg::IDLE;
			default:
				state_next = pitch_pkg::IDLE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////////
	// operator requests

	always_comb
	begin
		ops_req = '0;
		ops_req.op16 = pitch_pkg::OP_ADD;
		ops_req.op32 = pitch_pkg::OP_NONE;
		ops_req.la = s;
		case (state)
			pitch_pkg::NEGATE_FRAC:
			begin
				ops_req.op16 = pitch_pkg::OP_NEGATE;
				ops_req.a = req_q.frac;
			end
			pitch_pkg::ADJUST_FRAC:
			begin
				ops_req.a = frac1; // frac1 + 3, kept only if negative
				ops_req.b = `DATA_W'(`UP_SAMP);
			end
			pitch_pkg::SET_C2:
			begin
				ops_req.op16 = pitch_pkg::OP_SUB;
				ops_req.a = `DATA_W'(`UP_SAMP);
				ops_req.b = frac1;
			end
			pitch_pkg::I_LOOP:
			begin
				ops_req.op32 = pitch_pkg::OP_L_ADD; // rounding
				ops_req.lb = `ROUND_K;
			end
			pitch_pkg::MAC_X1, pitch_pkg::MAC_X2:
			begin
				ops_req.op32 = pitch_pkg::OP_L_MAC;
				ops_req.ma = eng_rdata;
				ops_req.mb = coef;
			end
			default:
				ops_req.op32 = pitch_pkg::OP_NONE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////////
	// state and loop counters

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= pitch_pkg::IDLE;
			j <= '0;
			i <= '0;
			k <= '0;
		end
		else
		begin
			state <= state_next;
			case (state)
				pitch_pkg::IDLE:
					j <= '0;
				pitch_pkg::J_LOOP:
				begin
					i <= '0;
					k <= '0;
				end
				pitch_pkg::MAC_X2:
				begin
					i <= i + 4'd1;
					k <= k + `COEF_AW'(`UP_SAMP);
				end
				pitch_pkg::STORE:
					j <= j_inc;
				default:
					j <= j;
			endcase
		end
	end

	// pointers, filter phases and accumulator
	always_ff @(posedge clk)
	begin
		case (state)
			pitch_pkg::IDLE:
				if (req)
					req_q <= req_data;
			pitch_pkg::NEGATE_FRAC:
			begin
				frac1 <= ops_rsp.r16;
				x0 <= req_q.base - req_q.t0[`EXC_AW-1:0]; // &exc[-t0]
			end
			pitch_pkg::ADJUST_FRAC:
				if (frac1[`DATA_W-1])
				begin
					frac1 <= ops_rsp.r16;
					x0 <= x0 - `EXC_AW'(1);
				end
			pitch_pkg::J_LOOP:
			begin
				x1 <= x0;
				x2 <= x0 + `EXC_AW'(1);
				x0 <= x0 + `EXC_AW'(1);
			end
			pitch_pkg::SET_C1:
			begin
				c1 <= frac1[`COEF_AW-1:0];
				s <= '0;
			end
			pitch_pkg::SET_C2:
				c2 <= ops_rsp.r16[`COEF_AW-1:0];
			pitch_pkg::MAC_X1, pitch_pkg::MAC_X2:
				s <= ops_rsp.r32;
			default:
				s <= s;
		endcase
	end

endmodule

// ==== source/basic_ops.sv ====
`timescale 1ns/1ps
`include "pitch_defines.svh"

module basic_ops
(
	input pitch_pkg::op_req_t ops_req,
	output pitch_pkg::op_rsp_t ops_rsp
);

	logic [`DATA_W:0] sum17; // one guard bit
	logic signed [`ACC_W-1:0] prod;
	logic [`ACC_W-1:0] mult;

	// clip a 17-bit result back into 16 bits
	function automatic logic [`DATA_W-1:0] sat16(input logic [`DATA_W:0] v);
		if (v[`DATA_W] != v[`DATA_W-1])
			sat16 = v[`DATA_W] ? 16'h8000 : 16'h7fff;
		else
			sat16 = v[`DATA_W-1:0];
	endfunction

	// L_add
	function automatic logic [`ACC_W-1:0] sat_add32(
		input logic [`ACC_W-1:0] x,
		input logic [`ACC_W-1:0] y
	);
		logic [`ACC_W:0] s33;
		s33 = {x[`ACC_W-1], x} + {y[`ACC_W-1], y};
		if (s33[`ACC_W] != s33[`ACC_W-1])
			sat_add32 = s33[`ACC_W] ? 32'h8000_0000 : 32'h7fff_ffff;
		else
			sat_add32 = s33[`ACC_W-1:0];
	endfunction

	//////////////////////////////////////////////////////////////////////////
	// 16-bit lane

	always_comb
	begin
		case (ops_req.op16)
			pitch_pkg::OP_ADD:
				sum17 = {ops_req.a[`DATA_W-1], ops_req.a} + {ops_req.b[`DATA_W-1], ops_req.b};
			pitch_pkg::OP_SUB:
				sum17 = {ops_req.a[`DATA_W-1], ops_req.a} - {ops_req.b[`DATA_W-1], ops_req.b};
			pitch_pkg::OP_NEGATE:
				sum17 = '0 - {ops_req.a[`DATA_W-1], ops_req.a}; // -32768 clips to 32767
			default:
				sum17 = '0;
		endcase
	end

	assign ops_rsp.r16 = sat16(sum17);

	//////////////////////////////////////////////////////////////////////////
	// 32-bit lane

	assign prod = $signed(ops_req.ma) * $signed(ops_req.mb);

	// L_mult, only 0x8000 * 0x8000 overflows after the doubling
	always_comb
	begin
		if (ops_req.ma == 16'h8000 && ops_req.mb == 16'h8000)
			mult = 32'h7fff_ffff;
		else
			mult = prod <<< 1;
	end

	always_comb
	begin
		case (ops_req.op32)
			pitch_pkg::OP_L_MAC:
				ops_rsp.r32 = sat_add32(ops_req.la, mult);
			pitch_pkg::OP_L_ADD:
				ops_rsp.r32 = sat_add32(ops_req.la, ops_req.lb);
			default:
				ops_rsp.r32 = ops_req.la; // pass accumulator
		endcase
	end

endmodule

// ==== source/exc_memory.sv ====
`timescale 1ns/1ps
`include "pitch_defines.svh"

module exc_memory
(
	input logic clk,
	input pitch_pkg::mem_port_t eng_mem,
	output logic [`DATA_W-1:0] eng_rdata,
	input pitch_pkg::mem_port_t host_mem,
	output logic [`DATA_W-1:0] host_rdata
);

	logic [`DATA_W-1:0] ram [0:`EXC_DEPTH-1];

	// both ports write, the handshake keeps them apart
	always_ff @(posedge clk)
	begin
		if (eng_mem.we)
			ram[eng_mem.addr] <= eng_mem.wdata;
		if (host_mem.we)
			ram[host_mem.addr] <= host_mem.wdata;
	end

	// registered reads, one cycle latency
	always_ff @(posedge clk)
	begin
		eng_rdata <= ram[eng_mem.addr];
		host_rdata <= ram[host_mem.addr];
	end

endmodule

// ==== source/inter_rom.sv ====
`timescale 1ns/1ps
`include "pitch_defines.svh"

module inter_rom
(
	input logic clk,
	input logic [`COEF_AW-1:0] coef_addr,
	output logic [`DATA_W-1:0] coef
);

	// inter_3l, Q15 windowed sinc at 1/3 resolution
	always_ff @(posedge clk)
	begin
		case (coef_addr)
			5'd0: coef <= 16'sd29443; // centre tap
			5'd1: coef <= 16'sd25207;
			5'd2: coef <= 16'sd14701;
			5'd3: coef <= 16'sd3143;
			5'd4: coef <= -16'sd4402;
			5'd5: coef <= -16'sd5850;
			5'd6: coef <= -16'sd2783;
			5'd7: coef <= 16'sd1211;
			5'd8: coef <= 16'sd3130;
			5'd9: coef <= 16'sd2259;
			5'd10: coef <= 16'sd0;
			5'd11: coef <= -16'sd1652;
			5'd12: coef <= -16'sd1666;
			5'd13: coef <= -16'sd464;
			5'd14: coef <= 16'sd756;
			5'd15: coef <= 16'sd1099;
			5'd16: coef <= 16'sd550;
			5'd17: coef <= -16'sd245;
			5'd18: coef <= -16'sd634;
			5'd19: coef <= -16'sd451;
			5'd20: coef <= 16'sd0;
			5'd21: coef <= 16'sd308;
			5'd22: coef <= 16'sd296;
			5'd23: coef <= 16'sd78;
			5'd24: coef <= -16'sd120;
			5'd25: coef <= -16'sd155;
			5'd26: coef <= -16'sd56;
			5'd27: coef <= 16'sd44;
			5'd28: coef <= 16'sd69;
			5'd29: coef <= 16'sd31;
			5'd30: coef <= 16'sd0;
			default: coef <= '0; // past the table
		endcase
	end

endmodule

// ==== source/pitch_interp_top.sv ====
`timescale 1ns/1ps
`include "pitch_defines.svh"

module pitch_interp_top
(
	input logic clk,
	input logic reset,
	input logic req,
	input pitch_pkg::pitch_req_t req_data,
	output logic ack,
	input pitch_pkg::mem_port_t host_mem,
	output logic [`DATA_W-1:0] host_rdata
);

	pitch_pkg::op_req_t ops_req;
	pitch_pkg::op_rsp_t ops_rsp;
	pitch_pkg::mem_port_t eng_mem;
	logic [`DATA_W-1:0] eng_rdata;
	logic [`COEF_AW-1:0] coef_addr;
	logic [`DATA_W-1:0] coef;

	// sequencer
	pred_lt_3_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.req(req),
		.req_data(req_data),
		.ack(ack),
		.ops_req(ops_req),
		.ops_rsp(ops_rsp),
		.eng_mem(eng_mem),
		.eng_rdata(eng_rdata),
		.coef_addr(coef_addr),
		.coef(coef)
	);

	basic_ops u_ops (
		.ops_req(ops_req),
		.ops_rsp(ops_rsp)
	);

	exc_memory u_mem (
		.clk(clk),
		.eng_mem(eng_mem),
		.eng_rdata(eng_rdata),
		.host_mem(host_mem),
		.host_rdata(host_rdata)
	);

	inter_rom u_rom (
		.clk(clk),
		.coef_addr(coef_addr),
		.coef(coef)
	);

endmodule

// ==== tests/tb_pitch_interp.sv ====
`timescale 1ns/1ps
`include "pitch_defines.svh"

module tb_pitch_interp;

	localparam int ACK_TIMEOUT = 5000; // cycles per wait
	localparam int J_CYCLES = 35; // per output sample
	localparam longint MAX32 = 64'sd2147483647;
	localparam longint MIN32 = -64'sd2147483648;

	logic clk;
	logic reset;
	logic req;
	pitch_pkg::pitch_req_t req_data;
	logic ack;
	pitch_pkg::mem_port_t host_mem;
	logic [`DATA_W-1:0] host_rdata;

	logic [`DATA_W-1:0] mem_img [0:`EXC_DEPTH-1]; // expected memory contents
	logic [15:0] lfsr;
	int sat_hits; // saturations seen by the model

	logic rd_valid;
	logic rd_valid_q;
	logic [`EXC_AW-1:0] rd_addr;
	logic [`EXC_AW-1:0] rd_addr_q;

	// inter_3l table in Q15 at 1/3 resolution
	shortint inter_3l [0:30] = '{
		29443, 25207, 14701, 3143, -4402, -5850, -2783, 1211, 3130, 2259,
		0, -1652, -1666, -464, 756, 1099, 550, -245, -634, -451,
		0, 308, 296, 78, -120, -155, -56, 44, 69, 31, 0
	};

	pitch_interp_top DUT (
		.clk(clk),
		.reset(reset),
		.req(req),
		.req_data(req_data),
		.ack(ack),
		.host_mem(host_mem),
		.host_rdata(host_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model built from the ITU basic operators

	function automatic int l_add(input int a, input int b);
		longint t;
		t = longint'(a) + longint'(b);
		if (t > MAX32)
		begin
			sat_hits++;
			return 32'h7fff_ffff;
		end
		if (t < MIN32)
		begin
			sat_hits++;
			return 32'h8000_0000;
		end
		return int'(t);
	endfunction

	function automatic int l_mult(input shortint a, input shortint b);
		if (a == 16'sh8000 && b == 16'sh8000)
			return 32'h7fff_ffff;
		return (int'(a) * int'(b)) * 2;
	endfunction

	function automatic logic [`DATA_W-1:0] round16(input int s);
		int t;
		t = l_add(s, 32'h0000_8000);
		return t[31:16];
	endfunction

	function automatic int neg16(input int v);
		if (v == -32768)
			return 32767;
		return -v;
	endfunction

	function automatic logic [`EXC_AW-1:0] wrap_addr(input int a);
		return a[`EXC_AW-1:0];
	endfunction

	// serial Pred_lt_3 on a copy of the image with in-place writes
	function automatic void interp_ref(input pitch_pkg::pitch_req_t r);
		logic [`DATA_W-1:0] m [0:`EXC_DEPTH-1];
		int frac1;
		int x0;
		int x1;
		int x2;
		int s;
		int j;
		int i;
		m = mem_img;
		x0 = int'(r.base) - int'(r.t0);
		frac1 = neg16(int'(r.frac));
		if (frac1 < 0)
		begin
			frac1 = frac1 + `UP_SAMP;
			x0 = x0 - 1;
		end
		for (j = 0; j < int'(r.l_subfr); j++)
		begin
			x1 = x0;
			x0 = x0 + 1;
			x2 = x0;
			s = 0;
			for (i = 0; i < `L_INTER; i++)
			begin
				s = l_add(s, l_mult(m[wrap_addr(x1 - i)], inter_3l[5'(frac1 + 3 * i)]));
				s = l_add(s, l_mult(m[wrap_addr(x2 + i)],
					inter_3l[5'(`UP_SAMP - frac1 + 3 * i)]));
			end
			m[wrap_addr(int'(r.base) + j)] = round16(s);
		end
		mem_img = m;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// checks

	task automatic fail_now();
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_sample(input string name, input logic [`DATA_W-1:0] got,
		input logic [`DATA_W-1:0] exp);
		if (got !== exp)
		begin
			$display("Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_ack(input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Error at %0d ns: ack got %b expected %b", $time, got, exp);
			fail_now();
		end
	endtask

	task automatic check_cycles(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("Error at %0d ns: %s got %0d expected %0d", $time, name, got, exp);
			fail_now();
		end
	endtask

	// read data comes back one cycle after the address
	always @(posedge clk)
	begin
		rd_valid_q <= rd_valid;
		rd_addr_q <= rd_addr;
	end

	always @(negedge clk)
	begin
		if (rd_valid_q === 1'b1)
			check_sample($sformatf("host_rdata[%0d]", rd_addr_q), host_rdata, mem_img[rd_addr_q]);
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus

	function automatic logic [15:0] galois_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hb400; // x^16 + x^14 + x^13 + x^11 + 1
		return n;
	endfunction

	task automatic random_word(output logic [`DATA_W-1:0] w);
		int b;
		for (b = 0; b < `DATA_W; b++)
		begin
			lfsr = galois_step(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	task automatic host_write(input logic [`EXC_AW-1:0] a, input logic [`DATA_W-1:0] d);
		@(posedge clk);
		host_mem.addr <= a;
		host_mem.wdata <= d;
		host_mem.we <= 1'b1;
		mem_img[a] = d;
	endtask

	task automatic host_release();
		@(posedge clk);
		host_mem.we <= 1'b0;
	endtask

	task automatic fill_random();
		int a;
		logic [`DATA_W-1:0] w;
		for (a = 0; a < `EXC_DEPTH; a++)
		begin
			random_word(w);
			host_write(a[`EXC_AW-1:0], w);
		end
		host_release();
	endtask

	// signs line up with inter_3l for the first output around center
	task automatic fill_full_scale(input logic [`EXC_AW-1:0] center);
		int a;
		logic [`EXC_AW-1:0] d;
		for (a = 0; a < `EXC_DEPTH; a++)
		begin
			d = a[`EXC_AW-1:0] - center;
			host_write(a[`EXC_AW-1:0], (d == '0 || d[0]) ? 16'h7fff : 16'h8001);
		end
		host_release();
	endtask

	task automatic read_back();
		int a;
		for (a = 0; a < `EXC_DEPTH; a++)
		begin
			@(posedge clk);
			host_mem.addr <= a[`EXC_AW-1:0];
			host_mem.we <= 1'b0;
			rd_addr <= a[`EXC_AW-1:0];
			rd_valid <= 1'b1;
		end
		@(posedge clk);
		rd_valid <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic wait_ack(input logic level, output int cycles);
		int n;
		n = 0;
		@(negedge clk);
		while (ack !== level)
		begin
			n++;
			if (n > ACK_TIMEOUT)
			begin
				$display("timeout: ack did not reach %b within %0d cycles at %0d ns",
					level, ACK_TIMEOUT, $time);
				fail_now();
			end
			@(negedge clk);
		end
		cycles = n;
	endtask

	// one four-phase request with req held high for hold extra cycles
	task automatic run_case(input int base, input int t0, input int frac,
		input int l_subfr, input int hold);
		pitch_pkg::pitch_req_t rq;
		int cycles;
		rq.base = base[`EXC_AW-1:0];
		rq.t0 = t0[15:0];
		rq.frac = frac[15:0];
		rq.l_subfr = l_subfr[15:0];
		interp_ref(rq);
		@(posedge clk);
		req_data <= rq;
		req <= 1'b1;
		wait_ack(1'b1, cycles);
		check_cycles("ack rise latency", cycles, 3 + J_CYCLES * l_subfr);
		repeat (hold)
		begin
			@(negedge clk);
			check_ack(ack, 1'b1);
		end
		@(posedge clk);
		req <= 1'b0;
		wait_ack(1'b0, cycles);
		check_cycles("ack fall latency", cycles, 1);
	endtask

	initial
	begin
		reset = 1'b1;
		req = 1'b0;
		req_data = '0;
		host_mem = '0;
		rd_valid = 1'b0;
		rd_addr = '0;
		lfsr = 16'd28617;
		sat_hits = 0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_ack(ack, 1'b0); // idle after reset

		fill_random();
		run_case(100, 60, 0, 40, 0);
		read_back();

		// negate, add 3 and x0 decrement
		fill_random();
		run_case(120, 50, 1, 40, 0);
		read_back();
		fill_random();
		run_case(80, 45, -1, 40, 0);
		read_back();

		fill_random();
		run_case(150, 25, 0, 40, 0); // short lag reads fresh outputs
		read_back();

		fill_full_scale(8'd60); // x0 = 100 - 40
		sat_hits = 0;
		run_case(100, 40, 0, 40, 0);
		read_back();
		if (sat_hits == 0)
		begin
			$display("full-scale run never saturated the model accumulator");
			fail_now();
		end

		// long req hold followed by a normal request on the same memory
		fill_random();
		run_case(200, 70, 1, 30, 20);
		read_back();
		run_case(60, 33, -1, 40, 0);
		read_back();

		$display("sim passed");
		$finish;
	end

endmodule
